//--- flist.f
hw/spi_cfg_pkg.sv
hw/spi_data_pkg.sv
hw/spi_config_regs.sv
hw/spi_channel.sv
hw/spi_rx_merge.sv
hw/spi_slave_top.sv
tb/tb_spi_slave_top.sv

//--- hw/spi_cfg_pkg.sv
/*
 * Bus configuration definitions: register map, configuration struct
 * and the register reset values
 */
package spi_cfg_pkg;

    localparam int CFG_ADDR_W = 2;
    localparam int CFG_DATA_W = 8;

    // Number of implemented bits in the control register
    localparam int CFG_CTRL_W = 4;

    // Longest frame the channels can shift
    localparam logic [CFG_DATA_W-1:0] CFG_LENGTH_MAX = 8'd16;

    typedef enum logic [CFG_ADDR_W-1:0] {
        CFG_CTRL   = 2'd0,
        CFG_LENGTH = 2'd1
    } cfg_reg_e;

    // Polarity is the idle SCLK level and a clear latching_edge samples on
    // the edge that leaves idle. A clear ss_polarity means active-low select
    typedef struct packed {
        logic                  clock_polarity;
        logic                  latching_edge;
        logic                  ss_polarity;
        logic                  msb_first;
        logic [CFG_DATA_W-1:0] transfer_length;
    } spi_cfg_t;

    localparam logic [CFG_CTRL_W-1:0] CFG_CTRL_RESET   = 4'b0000;
    localparam logic [CFG_DATA_W-1:0] CFG_LENGTH_RESET = 8'd16;

endpackage

//--- hw/spi_channel.sv
/*
 * One SPI slave channel: pin synchronizers, SCLK edge classification,
 * full-duplex shift registers and frame completion
 */
`timescale 1ns/1ps

module spi_channel (
    input  logic                               clock,
    input  logic                               rst_n,
    input  spi_cfg_pkg::spi_cfg_t              cfg,
    input  logic                               sclk,
    input  logic                               ss,
    input  logic                               mosi,
    output logic                               miso,
    input  logic                               tx_load,
    input  logic [spi_data_pkg::DATA_W-1:0]    tx_data,
    output logic                               rx_valid,
    output logic [spi_data_pkg::DATA_W-1:0]    rx_data,
    output logic                               active
);

    localparam int DW = spi_data_pkg::DATA_W;

    spi_data_pkg::chan_state_e state_q;

    // Two synchronizer flops and one edge register per pin
    logic [1:0] sclk_sync, ss_sync, mosi_sync;
    logic       sclk_q, ss_q, mosi_q;

    logic [7:0]    bit_cnt_q;
    logic [DW-1:0] tx_word_q;
    logic [DW-1:0] tx_shift_q;
    logic [DW-1:0] rx_shift_q;

    logic          sclk_edge, leading, sample_edge, drive_edge;
    logic          ss_on, ss_on_q, ss_start;
    logic          frame_start, in_frame, do_sample, do_drive, frame_done;
    logic [7:0]    shift_amt;
    logic [DW-1:0] tx_aligned, tx_next, rx_next;
    logic          tx_first_bit, tx_next_bit;

    assign sclk_edge   = sclk_sync[1] ^ sclk_q;
    // An edge is leading when the new level differs from the idle level
    assign leading     = sclk_edge & (sclk_sync[1] != cfg.clock_polarity);
    assign sample_edge = sclk_edge & (leading ^ cfg.latching_edge);
    assign drive_edge  = sclk_edge & ~sample_edge;

    assign ss_on    = (ss_sync[1] == cfg.ss_polarity);
    assign ss_on_q  = (ss_q == cfg.ss_polarity);
    assign ss_start = ss_on & ~ss_on_q;

    assign frame_start = (state_q == spi_data_pkg::CH_IDLE) & ss_start;
    assign in_frame    = (state_q == spi_data_pkg::CH_ACTIVE) & ss_on;
    assign do_sample   = in_frame & sample_edge;
    // No bit moves out before the first sample has been taken
    assign do_drive    = in_frame & drive_edge & (bit_cnt_q != '0);
    assign frame_done  = do_sample & ((bit_cnt_q + 8'd1) == cfg.transfer_length);

    assign shift_amt = 8'(DW) - cfg.transfer_length;

    // MSB-first words are moved up so that bit length-1 leaves first
    assign tx_aligned   = cfg.msb_first ? (tx_word_q << shift_amt) : tx_word_q;
    assign tx_next      = cfg.msb_first ? (tx_shift_q << 1) : (tx_shift_q >> 1);
    assign tx_first_bit = cfg.msb_first ? tx_aligned[DW-1] : tx_aligned[0];
    assign tx_next_bit  = cfg.msb_first ? tx_next[DW-1] : tx_next[0];

    assign rx_next = cfg.msb_first ? {rx_shift_q[DW-2:0], mosi_q} : {mosi_q, rx_shift_q[DW-1:1]};

    assign active = (state_q == spi_data_pkg::CH_ACTIVE);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            sclk_sync <= '0;
            ss_sync   <= '0;
            mosi_sync <= '0;
            sclk_q    <= 1'b0;
            ss_q      <= 1'b0;
            mosi_q    <= 1'b0;
            state_q   <= spi_data_pkg::CH_IDLE;
            bit_cnt_q <= '0;
            rx_valid  <= 1'b0;
            miso      <= 1'b0;
            tx_word_q <= '0;
        end else begin
            sclk_sync <= {sclk_sync[0], sclk};
            ss_sync   <= {ss_sync[0], ss};
            mosi_sync <= {mosi_sync[0], mosi};
            sclk_q    <= sclk_sync[1];
            ss_q      <= ss_sync[1];
            mosi_q    <= mosi_sync[1];
            rx_valid  <= frame_done;

            if (tx_load) begin
                tx_word_q <= tx_data;
            end

            case (state_q)
                spi_data_pkg::CH_IDLE: begin
                    if (ss_start) begin
                        state_q   <= spi_data_pkg::CH_ACTIVE;
                        bit_cnt_q <= '0;
                    end
                end
                spi_data_pkg::CH_ACTIVE: begin
                    // Releasing select early drops the frame silently
                    if (!ss_on || frame_done) begin
                        state_q <= spi_data_pkg::CH_IDLE;
                    end else if (do_sample) begin
                        bit_cnt_q <= bit_cnt_q + 8'd1;
                    end
                end
                default: state_q <= spi_data_pkg::CH_IDLE;
            endcase

            if (!ss_on) begin
                miso <= 1'b0;
            end else if (frame_start) begin
                miso <= tx_first_bit;
            end else if (do_drive) begin
                miso <= tx_next_bit;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (frame_start) begin
            rx_shift_q <= '0;
            tx_shift_q <= tx_aligned;
        end else begin
            if (do_sample) begin
                rx_shift_q <= rx_next;
            end
            if (do_drive) begin
                tx_shift_q <= tx_next;
            end
        end
        // LSB-first words collect at the top and are moved down on completion
        if (frame_done) begin
            rx_data <= cfg.msb_first ? rx_next : (rx_next >> shift_amt);
        end
    end

endmodule

//--- hw/spi_config_regs.sv
/*
 * Configuration register file with write strobe and combinational readback
 */
`timescale 1ns/1ps

module spi_config_regs (
    input  logic                               clock,
    input  logic                               rst_n,
    input  logic                               cfg_write,
    input  logic [spi_cfg_pkg::CFG_ADDR_W-1:0] cfg_addr,
    input  logic [spi_cfg_pkg::CFG_DATA_W-1:0] cfg_wdata,
    output logic [spi_cfg_pkg::CFG_DATA_W-1:0] cfg_rdata,
    output spi_cfg_pkg::spi_cfg_t              cfg
);

    logic [spi_cfg_pkg::CFG_CTRL_W-1:0] ctrl_q;
    logic [spi_cfg_pkg::CFG_DATA_W-1:0] length_q;
    spi_cfg_pkg::cfg_reg_e              reg_sel;

    assign reg_sel = spi_cfg_pkg::cfg_reg_e'(cfg_addr);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            ctrl_q   <= spi_cfg_pkg::CFG_CTRL_RESET;
            length_q <= spi_cfg_pkg::CFG_LENGTH_RESET;
        end else if (cfg_write) begin
            case (reg_sel)
                spi_cfg_pkg::CFG_CTRL: ctrl_q <= cfg_wdata[spi_cfg_pkg::CFG_CTRL_W-1:0];
                spi_cfg_pkg::CFG_LENGTH: begin
                    // Lengths the shifter cannot handle fall back to a full word
                    if (cfg_wdata == '0 || cfg_wdata > spi_cfg_pkg::CFG_LENGTH_MAX) begin
                        length_q <= spi_cfg_pkg::CFG_LENGTH_MAX;
                    end else begin
                        length_q <= cfg_wdata;
                    end
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        case (reg_sel)
            spi_cfg_pkg::CFG_CTRL: begin
                cfg_rdata = {{(spi_cfg_pkg::CFG_DATA_W - spi_cfg_pkg::CFG_CTRL_W){1'b0}}, ctrl_q};
            end
            spi_cfg_pkg::CFG_LENGTH: cfg_rdata = length_q;
            default:                 cfg_rdata = '0;
        endcase
    end

    assign cfg.clock_polarity  = ctrl_q[0];
    assign cfg.latching_edge   = ctrl_q[1];
    assign cfg.ss_polarity     = ctrl_q[2];
    assign cfg.msb_first       = ctrl_q[3];
    assign cfg.transfer_length = length_q;

endmodule

//--- hw/spi_data_pkg.sv
/*
 * Data path definitions: word width, channel count, channel states
 * and the tagged receive word
 */
package spi_data_pkg;

    // Width of the shift registers and of every received or sent word
    localparam int DATA_W = 16;

    localparam int N_CHANNELS = 2;

    // Enough bits to tag a word with its channel number
    localparam int CH_ID_W = 1;

    typedef enum logic {
        CH_IDLE   = 1'b0,
        CH_ACTIVE = 1'b1
    } chan_state_e;

    // Data is right aligned and zero filled above the transfer length
    typedef struct packed {
        logic [CH_ID_W-1:0] channel;
        logic [DATA_W-1:0]  data;
    } rx_word_t;

endpackage

//--- hw/spi_rx_merge.sv
/*
 * Merges the received words of all channels into one tagged stream
 * with fixed priority, and derives the bus idle level
 */
`timescale 1ns/1ps

module spi_rx_merge (
    input  logic                            clock,
    input  logic                            rst_n,
    input  logic [spi_data_pkg::N_CHANNELS-1:0] rx_valid,
    input  logic [spi_data_pkg::DATA_W-1:0] rx_data [spi_data_pkg::N_CHANNELS],
    input  logic [spi_data_pkg::N_CHANNELS-1:0] active,
    output logic                            out_valid,
    output spi_data_pkg::rx_word_t          out_word,
    output logic                            bus_idle
);

    logic [spi_data_pkg::N_CHANNELS-1:0] pending_q;
    logic [spi_data_pkg::DATA_W-1:0]     pend_data_q [spi_data_pkg::N_CHANNELS];
    logic [spi_data_pkg::CH_ID_W-1:0]    sel;

    // Scan from the top so that the lowest pending channel wins
    always_comb begin
        sel       = '0;
        out_valid = 1'b0;
        for (int i = spi_data_pkg::N_CHANNELS - 1; i >= 0; i--) begin
            if (pending_q[i]) begin
                sel       = spi_data_pkg::CH_ID_W'(i);
                out_valid = 1'b1;
            end
        end
    end

    assign out_word.channel = sel;
    assign out_word.data    = pend_data_q[sel];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pending_q <= '0;
        end else begin
            for (int i = 0; i < spi_data_pkg::N_CHANNELS; i++) begin
                if (rx_valid[i]) begin
                    pending_q[i] <= 1'b1;
                end else if (out_valid && (sel == spi_data_pkg::CH_ID_W'(i))) begin
                    pending_q[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < spi_data_pkg::N_CHANNELS; i++) begin
            if (rx_valid[i]) begin
                pend_data_q[i] <= rx_data[i];
            end
        end
    end

    // The bus is idle while no channel is inside a frame
    assign bus_idle = ~|active;

endmodule

//--- hw/spi_slave_top.sv
/*
 * Two-channel SPI slave: register file, two channels and the receive merger
 */
`timescale 1ns/1ps

module spi_slave_top (
    input  logic                                clock,
    input  logic                                rst_n,
    input  logic                                cfg_write,
    input  logic [spi_cfg_pkg::CFG_ADDR_W-1:0]  cfg_addr,
    input  logic [spi_cfg_pkg::CFG_DATA_W-1:0]  cfg_wdata,
    output logic [spi_cfg_pkg::CFG_DATA_W-1:0]  cfg_rdata,
    input  logic                                sclk,
    input  logic [spi_data_pkg::N_CHANNELS-1:0] ss,
    input  logic [spi_data_pkg::N_CHANNELS-1:0] mosi,
    output logic [spi_data_pkg::N_CHANNELS-1:0] miso,
    input  logic [spi_data_pkg::N_CHANNELS-1:0] tx_load,
    input  logic [spi_data_pkg::DATA_W-1:0]     tx_data [spi_data_pkg::N_CHANNELS],
    output logic                                out_valid,
    output spi_data_pkg::rx_word_t              out_word,
    output logic                                bus_idle
);

    spi_cfg_pkg::spi_cfg_t                cfg;
    logic [spi_data_pkg::N_CHANNELS-1:0]  rx_valid;
    logic [spi_data_pkg::DATA_W-1:0]      rx_data [spi_data_pkg::N_CHANNELS];
    logic [spi_data_pkg::N_CHANNELS-1:0]  active;

    spi_config_regs spi_config_regs_i (
        .clock     (clock),
        .rst_n     (rst_n),
        .cfg_write (cfg_write),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .cfg       (cfg)
    );

    // Both channels share SCLK and the configuration
    spi_channel chan_0_i (
        .clock (clock), .rst_n (rst_n), .cfg (cfg), .sclk (sclk),
        .ss (ss[0]), .mosi (mosi[0]), .miso (miso[0]),
        .tx_load (tx_load[0]), .tx_data (tx_data[0]),
        .rx_valid (rx_valid[0]), .rx_data (rx_data[0]), .active (active[0])
    );

    spi_channel chan_1_i (
        .clock (clock), .rst_n (rst_n), .cfg (cfg), .sclk (sclk),
        .ss (ss[1]), .mosi (mosi[1]), .miso (miso[1]),
        .tx_load (tx_load[1]), .tx_data (tx_data[1]),
        .rx_valid (rx_valid[1]), .rx_data (rx_data[1]), .active (active[1])
    );

    spi_rx_merge spi_rx_merge_i (
        .clock     (clock),
        .rst_n     (rst_n),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data),
        .active    (active),
        .out_valid (out_valid),
        .out_word  (out_word),
        .bus_idle  (bus_idle)
    );

endmodule

//--- tb/tb_spi_slave_top.sv
/*
 * Testbench for the two-channel SPI slave with an SPI master model,
 * register access tasks, a receive monitor and the directed and random tests
 */
`timescale 1ns/1ps

module tb_spi_slave_top;

    localparam int HALF = 8;
    // One full 16-bit frame with select setup and release
    localparam int FRAME_CYCLES = (2 * spi_data_pkg::DATA_W + 3) * HALF;
    // Twenty full frames plus margin, well above what the tests need
    localparam int TIMEOUT_CYCLES = 20 * FRAME_CYCLES + 400;

    logic        clock = 1'b0;
    logic        rst_n = 1'b0;
    logic        cfg_write = 1'b0;
    logic [1:0]  cfg_addr = '0;
    logic [7:0]  cfg_wdata = '0;
    logic [7:0]  cfg_rdata;
    logic        sclk = 1'b0;
    logic [1:0]  ss = 2'b11;
    logic [1:0]  mosi = 2'b00;
    logic [1:0]  miso;
    logic [1:0]  tx_load = 2'b00;
    logic [15:0] tx_data [2] = '{16'h0, 16'h0};
    logic        out_valid;
    logic        bus_idle;
    spi_data_pkg::rx_word_t out_word;

    spi_data_pkg::rx_word_t exp_q[$];
    spi_data_pkg::rx_word_t exp_word;
    logic        mode_cpol, mode_latch, mode_sspol, mode_msb;
    int          mode_len;
    logic [15:0] miso_word [2];
    int          last_cycle [2];
    int          cycle_count = 0;
    int          out_count = 0;
    int          errors = 0;
    int          test_start_errors = 0;
    int          tests_run = 0;
    int          tests_passed = 0;

    spi_slave_top spi_slave_top_i (
        .clock (clock), .rst_n (rst_n), .cfg_write (cfg_write), .cfg_addr (cfg_addr),
        .cfg_wdata (cfg_wdata), .cfg_rdata (cfg_rdata), .sclk (sclk), .ss (ss),
        .mosi (mosi), .miso (miso), .tx_load (tx_load), .tx_data (tx_data),
        .out_valid (out_valid), .out_word (out_word), .bus_idle (bus_idle)
    );

    always #2 clock = ~clock;

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the run did not finish", cycle_count);
            $display("tests failed");
            $finish;
        end
    end

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
        assert (got === exp) else begin
            $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    // Every received word must match the oldest expected one
    always @(negedge clock) begin
        if (rst_n && out_valid) begin
            assert (exp_q.size() != 0) else begin
                $display("%0t ns out_valid pulsed while no word was expected", $time);
                errors++;
            end
            if (exp_q.size() != 0) begin
                exp_word = exp_q.pop_front();
                compare_value("out_word", exp_word, out_word);
                last_cycle[exp_word.channel] = cycle_count;
            end
            out_count++;
        end
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clock);
    endtask

    task automatic write_reg(input logic [1:0] addr, input logic [7:0] data);
        @(negedge clock);
        cfg_addr  = addr;
        cfg_wdata = data;
        cfg_write = 1'b1;
        @(negedge clock);
        cfg_write = 1'b0;
    endtask

    task automatic check_reg(input string name, input logic [1:0] addr, input logic [7:0] exp);
        @(negedge clock);
        cfg_addr = addr;
        #1;
        compare_value(name, exp, cfg_rdata);
    endtask

    task automatic set_mode(input logic cpol, input logic latch, input logic sspol,
                            input logic msb, input int len);
        mode_cpol  = cpol;
        mode_latch = latch;
        mode_sspol = sspol;
        mode_msb   = msb;
        mode_len   = len;
        write_reg(spi_cfg_pkg::CFG_CTRL, {4'b0000, msb, sspol, latch, cpol});
        write_reg(spi_cfg_pkg::CFG_LENGTH, 8'(len));
        @(negedge clock);
        sclk = cpol;
        ss   = sspol ? 2'b00 : 2'b11;
        wait_cycles(6);
    endtask

    task automatic load_tx(input logic [15:0] t0, input logic [15:0] t1);
        @(negedge clock);
        tx_data[0] = t0;
        tx_data[1] = t1;
        tx_load    = 2'b11;
        @(negedge clock);
        tx_load = 2'b00;
    endtask

    function automatic int bit_index(input int k);
        return mode_msb ? mode_len - 1 - k : k;
    endfunction

    function automatic logic [15:0] len_mask(input int len);
        return 16'((32'd1 << len) - 32'd1);
    endfunction

    task automatic take_sample(input int idx);
        miso_word[0][idx] = miso[0];
        miso_word[1][idx] = miso[1];
        compare_value("bus_idle", 0, bus_idle);
    endtask

    // Master model that clocks n_bits bits on the selected channels in the current mode
    task automatic run_frame(input logic [1:0] sel, input int n_bits,
                             input logic [15:0] w0, input logic [15:0] w1);
        int idx;
        miso_word[0] = '0;
        miso_word[1] = '0;
        @(negedge clock);
        ss = mode_sspol ? sel : ~sel;
        if (!mode_latch) begin
            mosi = {w1[bit_index(0)], w0[bit_index(0)]};
        end
        wait_cycles(HALF);
        for (int k = 0; k < n_bits; k++) begin
            idx  = bit_index(k);
            sclk = ~mode_cpol;
            if (!mode_latch) begin
                take_sample(idx);
            end else begin
                mosi = {w1[idx], w0[idx]};
            end
            wait_cycles(HALF);
            sclk = mode_cpol;
            if (mode_latch) begin
                take_sample(idx);
            end else if (k + 1 < n_bits) begin
                mosi = {w1[bit_index(k + 1)], w0[bit_index(k + 1)]};
            end
            wait_cycles(HALF);
        end
        ss   = mode_sspol ? 2'b00 : 2'b11;
        mosi = 2'b00;
        wait_cycles(HALF);
    endtask

    task automatic drain_expected();
        while (exp_q.size() != 0) begin
            @(negedge clock);
        end
        wait_cycles(4);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_start_errors) begin
            tests_passed++;
            $display("Test %0d %s: ok", tests_run, name);
        end else begin
            $display("Test %0d %s: FAILED with %0d errors", tests_run, name,
                     errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    // Runs both channels at once with random words in the current mode
    task automatic dual_frame();
        logic [15:0] w0, w1, t0, t1;
        w0 = 16'($urandom);
        w1 = 16'($urandom);
        t0 = 16'($urandom);
        t1 = 16'($urandom);
        load_tx(t0, t1);
        exp_q.push_back('{channel: 1'b0, data: w0 & len_mask(mode_len)});
        exp_q.push_back('{channel: 1'b1, data: w1 & len_mask(mode_len)});
        run_frame(2'b11, mode_len, w0, w1);
        drain_expected();
        compare_value("miso[0] word", t0 & len_mask(mode_len), miso_word[0]);
        compare_value("miso[1] word", t1 & len_mask(mode_len), miso_word[1]);
        compare_value("channel 1 lag", 1, last_cycle[1] - last_cycle[0]);
    endtask

    initial begin
        logic [15:0] w, t;
        int count_before;
        void'($urandom(32'h5a1c));
        repeat (8) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
        wait_cycles(2);

        compare_value("out_valid", 0, out_valid);
        compare_value("bus_idle", 1, bus_idle);
        compare_value("miso", 0, miso);
        check_reg("CTRL", spi_cfg_pkg::CFG_CTRL, 8'h00);
        check_reg("LENGTH", spi_cfg_pkg::CFG_LENGTH, 8'd16);
        finish_test("reset values");

        write_reg(spi_cfg_pkg::CFG_CTRL, 8'hFA);
        check_reg("CTRL", spi_cfg_pkg::CFG_CTRL, 8'h0A);
        write_reg(spi_cfg_pkg::CFG_LENGTH, 8'd5);
        check_reg("LENGTH", spi_cfg_pkg::CFG_LENGTH, 8'd5);
        write_reg(spi_cfg_pkg::CFG_LENGTH, 8'd0);
        check_reg("LENGTH", spi_cfg_pkg::CFG_LENGTH, 8'd16);
        write_reg(spi_cfg_pkg::CFG_LENGTH, 8'd20);
        check_reg("LENGTH", spi_cfg_pkg::CFG_LENGTH, 8'd16);
        finish_test("register readback");

        set_mode(1'b0, 1'b0, 1'b0, 1'b1, 16);
        dual_frame();
        finish_test("mode 0 msb first 16 bits");

        set_mode(1'b1, 1'b1, 1'b1, 1'b0, 8);
        dual_frame();
        finish_test("mode 3 lsb first 8 bits");

        set_mode(1'b0, 1'b0, 1'b0, 1'b1, 16);
        w = 16'($urandom);
        t = 16'($urandom);
        load_tx(16'h0000, t);
        count_before = out_count;
        exp_q.push_back('{channel: 1'b1, data: w});
        run_frame(2'b10, 16, 16'h0000, w);
        drain_expected();
        compare_value("out_word count", count_before + 1, out_count);
        compare_value("miso[1] word", t, miso_word[1]);
        compare_value("bus_idle", 1, bus_idle);
        // Select released after five bits, so nothing may come out
        run_frame(2'b10, 5, 16'h0000, 16'($urandom));
        wait_cycles(20);
        compare_value("out_word count", count_before + 1, out_count);
        compare_value("bus_idle", 1, bus_idle);
        finish_test("single channel and abort");

        $display("Tests run %0d, passed %0d, errors %0d", tests_run, tests_passed, errors);
        if (errors == 0 && tests_passed == tests_run) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
